/* design/fabric_top.sv */
// fabric top: key debounce, hps reset pulses, heartbeat led, trace-event packing
`timescale 1ns/1ps

module fabric_top #(
  parameter int DEBOUNCE_TIMEOUT = ghrd_pkg::DEBOUNCE_TIMEOUT_DEF,
  parameter int COLD_PULSE       = ghrd_pkg::COLD_PULSE_DEF,
  parameter int WARM_PULSE       = ghrd_pkg::WARM_PULSE_DEF,
  parameter int DEBUG_PULSE      = ghrd_pkg::DEBUG_PULSE_DEF,
  parameter int HEARTBEAT_HALF   = ghrd_pkg::HEARTBEAT_HALF_DEF
) (
  input  logic                     fpga_clk_50,
  input  logic                     hps_fpga_reset_n, // from the hps h2f reset
  input  ghrd_pkg::key_t           key,              // raw push-keys, active low
  input  ghrd_pkg::sw_t            sw,
  input  ghrd_pkg::led_pio_t       led_pio,          // processor led pio
  input  ghrd_pkg::reset_req_t     reset_req,        // request levels, active high
  output ghrd_pkg::ledr_t          ledr,
  output ghrd_pkg::reset_req_t     f2h_reset_req_n,  // pulses to the reset manager
  output ghrd_pkg::stm_hw_events_t stm_hw_events
);

  import ghrd_pkg::*;

  key_t debounced_keys;  // active low, also read back by the processor
  logic heartbeat_level;

  // ========================================
  // key debounce
  // ========================================
  key_debounce #(
    .TIMEOUT (DEBOUNCE_TIMEOUT)
  ) u_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_clean        (debounced_keys)
  );

  // ========================================
  // hps reset requests
  // ========================================
  reset_pulse_gen #(
    .PULSE_CYCLES (COLD_PULSE)
  ) u_cold (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req.cold),
    .req_pulse_n      (f2h_reset_req_n.cold)
  );

  reset_pulse_gen #(
    .PULSE_CYCLES (WARM_PULSE)
  ) u_warm (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req.warm),
    .req_pulse_n      (f2h_reset_req_n.warm)
  );

  reset_pulse_gen #(
    .PULSE_CYCLES (DEBUG_PULSE)
  ) u_debug (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req.debug),
    .req_pulse_n      (f2h_reset_req_n.debug)
  );

  // ========================================
  // heartbeat and outputs
  // ========================================
  heartbeat_blinker #(
    .HALF_PERIOD (HEARTBEAT_HALF)
  ) u_blinker (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_level        (heartbeat_level)
  );

  assign ledr = {led_pio, heartbeat_level}; // pio on 9:1, heartbeat on 0

  // trace word is pure wiring, same cycle as its sources
  assign stm_hw_events = '{
    pad:     '0,
    sw:      sw,
    led:     led_pio,
    buttons: debounced_keys
  };

endmodule

/* design/ghrd_pkg.sv */
// shared widths, request and trace-event structs, pulse states, default constants
package ghrd_pkg;

  // ========================================
  // board vector widths
  // ========================================
  typedef logic [3:0] key_t;     // push-keys, active low
  typedef logic [9:0] sw_t;      // slide switches
  typedef logic [8:0] led_pio_t; // leds driven by the processor pio
  typedef logic [9:0] ledr_t;    // board leds, bit 0 is the heartbeat

  // ========================================
  // grouped signals
  // ========================================

  // one bit per reset domain of the hps reset manager
  // cold sits in bit 0, as on the source/probe request vector
  typedef struct packed {
    logic debug; // bit 2
    logic warm;  // bit 1
    logic cold;  // bit 0
  } reset_req_t;

  // word for the stm hardware-event port, msb first
  typedef struct packed {
    logic [4:0] pad;     // fills the 28-bit event port, always zero
    sw_t        sw;      // [22:13]
    led_pio_t   led;     // [12:4]
    key_t       buttons; // [3:0] debounced keys
  } stm_hw_events_t;

  // reset pulse fsm
  typedef enum logic {
    PULSE_IDLE   = 1'b0, // output released
    PULSE_ACTIVE = 1'b1  // output held low
  } pulse_state_e;

  // ========================================
  // defaults for a 50 MHz fabric clock
  // ========================================
  localparam int DEBOUNCE_TIMEOUT_DEF = 50000;    // 1 ms of stable key level
  localparam int COLD_PULSE_DEF       = 6;        // cycles low
  localparam int WARM_PULSE_DEF       = 2;
  localparam int DEBUG_PULSE_DEF      = 32;
  localparam int HEARTBEAT_HALF_DEF   = 25000000; // 0.5 s per led phase

endpackage

/* design/heartbeat_blinker.sv */
// free-running divider toggling the heartbeat led
`timescale 1ns/1ps

module heartbeat_blinker #(
  parameter int HALF_PERIOD = ghrd_pkg::HEARTBEAT_HALF_DEF // cycles per led phase
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led_level  // 1 = led on
);

  localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t cnt; // 0 .. HALF_PERIOD-1
  logic wrap;

  assign wrap = (cnt == cnt_t'(HALF_PERIOD - 1)); // last cycle of the phase

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt       <= '0;
      led_level <= 1'b0; // dark out of reset
    end
    else if (wrap)
    begin
      cnt       <= '0;
      led_level <= ~led_level; // flip once per half period
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* design/key_debounce.sv */
// push-key synchronizer and per-key stability counters
`timescale 1ns/1ps

module key_debounce #(
  parameter int TIMEOUT = ghrd_pkg::DEBOUNCE_TIMEOUT_DEF // stable cycles to accept a level
) (
  input  logic           fpga_clk_50,
  input  logic           hps_fpga_reset_n,
  input  ghrd_pkg::key_t key_raw,   // straight from the pads, async
  output ghrd_pkg::key_t key_clean  // debounced, still active low
);

  import ghrd_pkg::*;

  localparam int N_KEYS = $bits(key_t);
  localparam int CNT_W  = (TIMEOUT > 0) ? $clog2(TIMEOUT + 1) : 1; // must hold TIMEOUT itself

  typedef logic [CNT_W-1:0] cnt_t;

  // ========================================
  // clock-domain crossing
  // ========================================
  key_t key_meta; // first flop, may go metastable
  key_t key_sync; // second flop, safe to use

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1; // released
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key_raw;
      key_sync <= key_meta;
    end
  end

  // ========================================
  // stability counters
  // ========================================
  cnt_t cnt [N_KEYS]; // cycles the synced bit has disagreed with the clean bit

  // counter runs while the synced level differs from the accepted one
  // any return to the accepted level throws the count away
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      for (int i = 0; i < N_KEYS; i++)
      begin
        cnt[i] <= '0;
      end
      key_clean <= '1; // all keys up after reset
    end
    else
    begin
      for (int i = 0; i < N_KEYS; i++)
      begin
        if (key_sync[i] == key_clean[i])
        begin
          cnt[i] <= '0; // bounce back, start over
        end
        else if (cnt[i] == cnt_t'(TIMEOUT))
        begin
          key_clean[i] <= key_sync[i]; // held long enough, accept
          cnt[i]       <= '0;
        end
        else
        begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

/* design/reset_pulse_gen.sv */
// rising-edge detector stretching a request into a fixed-length active-low pulse
`timescale 1ns/1ps

module reset_pulse_gen #(
  parameter int PULSE_CYCLES = ghrd_pkg::COLD_PULSE_DEF // length of the low pulse
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,          // request level, synchronous to the fabric clock
  output logic req_pulse_n   // to the hps reset manager, active low
);

  import ghrd_pkg::*;

  localparam int CNT_W = (PULSE_CYCLES > 1) ? $clog2(PULSE_CYCLES) : 1;

  typedef logic [CNT_W-1:0] cnt_t;

  // ========================================
  // edge detection
  // ========================================
  logic req_q;    // request delayed one cycle
  logic req_rise; // level went 0 -> 1

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q <= 1'b0;
    end
    else
    begin
      req_q <= req; // keeps tracking even while a pulse runs
    end
  end

  assign req_rise = req & ~req_q;

  // ========================================
  // pulse fsm
  // ========================================
  pulse_state_e state;
  cnt_t         cnt;   // cycles left after the current one

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state <= PULSE_IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        PULSE_IDLE:
        begin
          if (req_rise)
          begin
            state <= PULSE_ACTIVE;
            cnt   <= cnt_t'(PULSE_CYCLES - 1); // this edge starts cycle one
          end
        end
        PULSE_ACTIVE:
        begin
          // new edges are ignored here, the pulse is not restarted
          if (cnt == '0)
          begin
            state <= PULSE_IDLE;
          end
          else
          begin
            cnt <= cnt - 1'b1;
          end
        end
        default:
        begin
          state <= PULSE_IDLE;
        end
      endcase
    end
  end

  // low exactly while the fsm is active, straight off a flop
  assign req_pulse_n = (state != PULSE_ACTIVE);

endmodule

/* flist.f */
design/ghrd_pkg.sv
design/key_debounce.sv
design/reset_pulse_gen.sv
design/heartbeat_blinker.sv
design/fabric_top.sv
testbench/fabric_top_sva.sv
testbench/tb_fabric_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fabric_top simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fabric_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* testbench/fabric_top_sva.sv */
// bound checks: reset values, pulse lengths, debounce window, heartbeat phases, output packing
`timescale 1ns/1ps

module fabric_top_sva #(
  parameter int DEBOUNCE_TIMEOUT = 8,
  parameter int COLD_PULSE       = 6,
  parameter int WARM_PULSE       = 2,
  parameter int DEBUG_PULSE      = 32,
  parameter int HEARTBEAT_HALF   = 20
) (
  input logic                     fpga_clk_50,
  input logic                     hps_fpga_reset_n,
  input ghrd_pkg::key_t           key,
  input ghrd_pkg::sw_t            sw,
  input ghrd_pkg::led_pio_t       led_pio,
  input ghrd_pkg::reset_req_t     reset_req,
  input ghrd_pkg::ledr_t          ledr,
  input ghrd_pkg::reset_req_t     f2h_reset_req_n,
  input ghrd_pkg::stm_hw_events_t stm_hw_events
);

  import ghrd_pkg::*;

  logic       failed = 1'b0; // polled by the testbench
  reset_req_t req_prev;
  int         rem [3];       // low cycles still owed per domain
  key_t       hist [DEBOUNCE_TIMEOUT+2]; // past key samples, newest first
  key_t       exp_keys;
  logic       hb_prev;
  int         phase_len;     // samples seen at the current led level

  function automatic int pulse_len(int i);
    case (i)
      0: return COLD_PULSE;
      1: return WARM_PULSE;
      default: return DEBUG_PULSE;
    endcase
  endfunction

  // ========================================
  // reference model
  // ========================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_prev <= '0;
      for (int i = 0; i < 3; i++)
      begin
        rem[i] <= 0;
      end
      for (int j = 0; j < DEBOUNCE_TIMEOUT + 2; j++)
      begin
        hist[j] <= '1;
      end
      exp_keys  <= '1;
      hb_prev   <= 1'b0;
      phase_len <= 0;
    end
    else
    begin
      req_prev <= reset_req;
      for (int i = 0; i < 3; i++)
      begin
        if (rem[i] == 0 && reset_req[i] && !req_prev[i])
          rem[i] <= pulse_len(i); // new edge only when idle
        else if (rem[i] != 0)
          rem[i] <= rem[i] - 1;
      end
      hist[0] <= key;
      for (int j = 1; j < DEBOUNCE_TIMEOUT + 2; j++)
      begin
        hist[j] <= hist[j-1];
      end
      // flip when the whole window disagrees with the accepted level
      for (int k = 0; k < 4; k++)
      begin
        if (window_differs(k))
          exp_keys[k] <= ~exp_keys[k];
      end
      hb_prev   <= ledr[0];
      phase_len <= (ledr[0] != hb_prev) ? 1 : phase_len + 1;
    end
  end

  function automatic logic window_differs(int k);
    for (int j = 1; j <= DEBOUNCE_TIMEOUT + 1; j++)
    begin
      if (hist[j][k] == exp_keys[k])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // ========================================
  // assertions
  // ========================================
  a_reset_values: assert property (@(posedge fpga_clk_50)
    $rose(hps_fpga_reset_n) |->
      (f2h_reset_req_n == '1 && !ledr[0] && stm_hw_events.buttons == '1))
    else begin failed = 1'b1; $error("[ERROR] %0t outputs not at reset values", $time); end

  a_cold: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    f2h_reset_req_n.cold == (rem[0] == 0))
    else begin failed = 1'b1; $error("[ERROR] %0t cold pulse wrong", $time); end

  a_warm: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    f2h_reset_req_n.warm == (rem[1] == 0))
    else begin failed = 1'b1; $error("[ERROR] %0t warm pulse wrong", $time); end

  a_debug: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    f2h_reset_req_n.debug == (rem[2] == 0))
    else begin failed = 1'b1; $error("[ERROR] %0t debug pulse wrong", $time); end

  a_debounce: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    stm_hw_events.buttons == exp_keys)
    else begin failed = 1'b1; $error("[ERROR] %0t debounced keys wrong", $time); end

  a_hb_phase: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    (ledr[0] != hb_prev) |-> phase_len == HEARTBEAT_HALF)
    else begin failed = 1'b1; $error("[ERROR] %0t heartbeat phase too short", $time); end

  a_hb_max: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    phase_len <= HEARTBEAT_HALF)
    else begin failed = 1'b1; $error("[ERROR] %0t heartbeat stuck", $time); end

  a_packing: assert property (@(posedge fpga_clk_50)
    stm_hw_events.pad == '0 && stm_hw_events.sw == sw
      && stm_hw_events.led == led_pio && ledr[9:1] == led_pio)
    else begin failed = 1'b1; $error("[ERROR] %0t output packing wrong", $time); end

endmodule

bind fabric_top fabric_top_sva #(
  .DEBOUNCE_TIMEOUT (DEBOUNCE_TIMEOUT),
  .COLD_PULSE       (COLD_PULSE),
  .WARM_PULSE       (WARM_PULSE),
  .DEBUG_PULSE      (DEBUG_PULSE),
  .HEARTBEAT_HALF   (HEARTBEAT_HALF)
) u_sva (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .key              (key),
  .sw               (sw),
  .led_pio          (led_pio),
  .reset_req        (reset_req),
  .ledr             (ledr),
  .f2h_reset_req_n  (f2h_reset_req_n),
  .stm_hw_events    (stm_hw_events)
);

/* testbench/tb_fabric_top.sv */
// testbench: clock, reset, random stimulus for pulses, keys, switches and heartbeat
`timescale 1ns/1ps

module tb_fabric_top;

  import ghrd_pkg::*;

  localparam int T = 8; // debounce timeout

  logic                fpga_clk_50;
  logic                hps_fpga_reset_n;
  key_t                key;
  sw_t                 sw;
  led_pio_t            led_pio;
  reset_req_t          reset_req;
  ledr_t               ledr;
  reset_req_t          f2h_reset_req_n;
  stm_hw_events_t      stm_hw_events;

  fabric_top #(
    .DEBOUNCE_TIMEOUT (T),
    .COLD_PULSE       (6),
    .WARM_PULSE       (2),
    .DEBUG_PULSE      (32),
    .HEARTBEAT_HALF   (20)
  ) dut (.*);

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #50 fpga_clk_50 = ~fpga_clk_50;
  end

  // first assertion failure ends the run
  always @(negedge fpga_clk_50)
  begin
    if (dut.u_sva.failed)
    begin
      $display(">>> FAIL");
      $fatal(1, "assertion failed");
    end
  end

  // one cycle with fresh switch and pio values
  task automatic step(int n);
    repeat (n)
    begin
      @(posedge fpga_clk_50);
      sw      <= sw_t'($urandom);
      led_pio <= led_pio_t'($urandom);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timed out waiting for %s", what);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic wait_pulse_level(int idx, logic level, int limit);
    int n;
    n = 0;
    while (f2h_reset_req_n[idx] !== level)
    begin
      if (n++ >= limit)
        timeout_fail($sformatf("reset request %0d to reach %0b", idx, level));
      step(1);
    end
  endtask

  // edge on one request, then a repeat edge two cycles later
  // repeat lands while even the 2-cycle warm pulse is still active
  task automatic pulse_run(int idx);
    step(1);
    reset_req[idx] <= 1'b1;
    step(1);
    reset_req[idx] <= 1'b0;
    step(1);
    reset_req[idx] <= 1'b1; // ignored, pulse already running
    wait_pulse_level(idx, 1'b1, 40);
    reset_req[idx] <= 1'b0;
    step(1 + $urandom_range(0, 3));
  endtask

  task automatic key_glitch(int k);
    step(1);
    key[k] <= ~key[k];
    step($urandom_range(1, 7));
    key[k] <= ~key[k];
    step(T + 6); // let the window drain
  endtask

  task automatic key_change(int k);
    int n;
    step(1);
    key[k] <= ~key[k];
    step(1);
    n = 0;
    while (stm_hw_events.buttons[k] !== key[k])
    begin
      if (n++ >= T + 8)
        timeout_fail($sformatf("key %0d to pass the debouncer", k));
      step(1);
    end
  endtask

  task automatic wait_heartbeat_toggles(int count);
    logic last;
    int   n;
    for (int i = 0; i < count; i++)
    begin
      last = ledr[0];
      n    = 0;
      while (ledr[0] === last)
      begin
        if (n++ >= 100)
          timeout_fail("the heartbeat led to toggle");
        step(1);
      end
    end
  endtask

  initial
  begin
    void'($urandom(74));
    hps_fpga_reset_n = 1'b0;
    key              = '1;
    sw               = '0;
    led_pio          = '0;
    reset_req        = '0;
    repeat (8) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;
    step(2);

    // ========================================
    // stimulus
    // ========================================
    for (int r = 0; r < 6; r++)
    begin
      pulse_run(r % 3); // each domain twice
    end
    for (int r = 0; r < 8; r++)
    begin
      key_glitch($urandom_range(0, 3));
    end
    for (int r = 0; r < 6; r++)
    begin
      key_change($urandom_range(0, 3)); // press or release
    end
    wait_heartbeat_toggles(4);
    step(4);

    if (dut.u_sva.failed)
    begin
      $display(">>> FAIL");
      $fatal(1, "assertion failed");
    end
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
